/* hdl/axi_mem_pkg.sv */
/*
 * AXI memory slave shared definitions
 * Bus widths, memory depth, channel field types and the burst and
 * response encodings used across the design
 */
`default_nettype none

package axi_mem_pkg;

    // Memory geometry
    localparam int MEM_DEPTH     = 1024;                // Bytes
    localparam int MEM_IDX_WIDTH = $clog2(MEM_DEPTH);   // Byte index into the array

    // Channel field widths
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;         // One strobe per byte lane
    localparam int ID_WIDTH   = 4;
    localparam int LEN_WIDTH  = 8;                      // Beats minus one
    localparam int SIZE_WIDTH = 3;                      // log2 of bytes per beat

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [ID_WIDTH-1:0]   id_t;
    typedef logic [LEN_WIDTH-1:0]  len_t;
    typedef logic [SIZE_WIDTH-1:0] size_t;

    // AxBURST encoding
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_t;

    // xRESP encoding, only the two codes this slave returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_t;

endpackage

`default_nettype wire

/* hdl/axi_mem_slave.sv */
/*
 * AXI4 style burst memory slave, top level
 * One read or write burst at a time into a byte addressed array
 */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_slave import axi_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        arvalid,    // Read address
    output logic        arready,
    input  id_t         arid,
    input  addr_t       araddr,
    input  len_t        arlen,
    input  size_t       arsize,
    input  logic [1:0]  arburst,

    output logic        rvalid,     // Read data
    input  logic        rready,
    output id_t         rid,
    output data_t       rdata,
    output logic [1:0]  rresp,
    output logic        rlast,

    input  logic        awvalid,    // Write address
    output logic        awready,
    input  id_t         awid,
    input  addr_t       awaddr,
    input  len_t        awlen,
    input  size_t       awsize,
    input  logic [1:0]  awburst,

    input  logic        wvalid,     // Write data
    output logic        wready,
    input  data_t       wdata,
    input  strb_t       wstrb,

    output logic        bvalid,     // Write response
    input  logic        bready,
    output id_t         bid,
    output logic [1:0]  bresp
);

    logic load;
    logic is_write;
    logic start;
    logic advance;
    logic last_beat;

    burst_cmd_if cmd_bus ();
    mem_port_if  mem_bus ();

    burst_cmd_reg u_cmd_reg (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .is_write (is_write),
        .arid     (arid),
        .araddr   (araddr),
        .arlen    (arlen),
        .arsize   (arsize),
        .arburst  (arburst),
        .awid     (awid),
        .awaddr   (awaddr),
        .awlen    (awlen),
        .awsize   (awsize),
        .awburst  (awburst),
        .cmd      (cmd_bus)
    );

    burst_addr_gen u_addr_gen (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .advance   (advance),
        .cmd       (cmd_bus),
        .mem       (mem_bus),
        .last_beat (last_beat)
    );

    slave_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .arvalid   (arvalid),
        .awvalid   (awvalid),
        .wvalid    (wvalid),
        .rready    (rready),
        .bready    (bready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .arready   (arready),
        .awready   (awready),
        .wready    (wready),
        .rvalid    (rvalid),
        .rid       (rid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .bvalid    (bvalid),
        .bid       (bid),
        .bresp     (bresp),
        .load      (load),
        .is_write  (is_write),
        .start     (start),
        .advance   (advance),
        .last_beat (last_beat),
        .cmd       (cmd_bus),
        .mem       (mem_bus)
    );

    byte_mem u_mem (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus)
    );

endmodule

`default_nettype wire

/* hdl/burst_addr_gen.sv */
/*
 * Burst address generator
 * Tracks the beat address and beat count for FIXED, INCR and WRAP bursts
 * and flags the final beat
 */
`timescale 1ns/100ps
`default_nettype none

module burst_addr_gen import axi_mem_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         start,      // New burst accepted
    input  logic         advance,    // Beat handshake, step to next address
    burst_cmd_if.cmd_dst cmd,
    mem_port_if.host     mem,
    output logic         last_beat
);

    addr_t cur_addr;                   // Address of beats after the first
    len_t  beat_cnt;
    logic  at_start;                   // First beat uses the command address

    addr_t nbytes;                     // Bytes per beat
    addr_t wrap_bytes;                 // Bytes in one wrap block
    addr_t wrap_base;                  // Lower wrap boundary
    logic [ADDR_WIDTH:0] incr_addr;    // Extra bit so the compare never overflows
    logic [ADDR_WIDTH:0] wrap_end;
    addr_t next_addr;

    // Command register loads on the same edge as start,
    // so beat 0 reads the address straight from the command
    assign mem.addr  = at_start ? cmd.addr : cur_addr;
    assign mem.size  = cmd.size;
    assign last_beat = (beat_cnt == cmd.len);

    always_comb begin
        nbytes     = addr_t'(1) << cmd.size;
        wrap_bytes = (addr_t'(cmd.len) + addr_t'(1)) << cmd.size;   // Power of two for WRAP
        wrap_base  = cmd.addr & ~(wrap_bytes - addr_t'(1));         // Round start down
        incr_addr  = {1'b0, mem.addr} + {1'b0, nbytes};
        wrap_end   = {1'b0, wrap_base} + {1'b0, wrap_bytes};

        case (cmd.burst)
            BURST_FIXED: next_addr = mem.addr;                      // Same address every beat
            BURST_WRAP: begin
                if (incr_addr >= wrap_end)
                    next_addr = wrap_base;                          // Back to the block start
                else
                    next_addr = incr_addr[ADDR_WIDTH-1:0];
            end
            default:     next_addr = incr_addr[ADDR_WIDTH-1:0];     // INCR
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cur_addr <= '0;
            beat_cnt <= '0;
            at_start <= 1'b0;
        end else if (start) begin
            beat_cnt <= '0;
            at_start <= 1'b1;
        end else if (advance) begin
            cur_addr <= next_addr;
            beat_cnt <= beat_cnt + 1'b1;
            at_start <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/burst_cmd_if.sv */
/*
 * Burst command bundle
 * Holds the captured address channel fields for the burst in flight
 */
`timescale 1ns/100ps
`default_nettype none

interface burst_cmd_if import axi_mem_pkg::*; ();

    id_t    id;     // Transaction ID, echoed on R and B
    addr_t  addr;   // Start address of the burst
    len_t   len;    // Beats minus one
    size_t  size;   // log2 bytes per beat
    burst_t burst;  // FIXED, INCR or WRAP

    // Command register side
    modport cmd_src (
        output id, addr, len, size, burst
    );

    // Address generator and controller side
    modport cmd_dst (
        input id, addr, len, size, burst
    );

endinterface

`default_nettype wire

/* hdl/burst_cmd_reg.sv */
/*
 * Burst command register
 * Picks the AR or AW fields and holds them for the length of the burst
 */
`timescale 1ns/100ps
`default_nettype none

module burst_cmd_reg import axi_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        load,       // Address handshake this cycle
    input  logic        is_write,   // Take AW fields instead of AR

    input  id_t         arid,
    input  addr_t       araddr,
    input  len_t        arlen,
    input  size_t       arsize,
    input  logic [1:0]  arburst,

    input  id_t         awid,
    input  addr_t       awaddr,
    input  len_t        awlen,
    input  size_t       awsize,
    input  logic [1:0]  awburst,

    burst_cmd_if.cmd_src cmd
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cmd.id    <= '0;
            cmd.addr  <= '0;
            cmd.len   <= '0;
            cmd.size  <= '0;
            cmd.burst <= BURST_FIXED;
        end else if (load) begin
            // Write side wins only when the controller granted AW
            cmd.id    <= is_write ? awid   : arid;
            cmd.addr  <= is_write ? awaddr : araddr;
            cmd.len   <= is_write ? awlen  : arlen;
            cmd.size  <= is_write ? awsize : arsize;
            cmd.burst <= burst_t'(is_write ? awburst : arburst);    // Raw field to enum
        end
    end

endmodule

`default_nettype wire

/* hdl/byte_mem.sv */
/*
 * Byte wide memory array
 * Lane aligned combinational read, strobed write and beat range check
 */
`timescale 1ns/100ps
`default_nettype none

module byte_mem import axi_mem_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    mem_port_if.mem mem
);

    logic [7:0]               mem_array [MEM_DEPTH];
    strb_t                    lane_mask;               // Lanes covered by the beat size
    logic [ADDR_WIDTH:0]      end_addr;                // Last byte of the beat
    logic [MEM_IDX_WIDTH-1:0] lane_idx [STRB_WIDTH];

    // Byte i of the beat always sits on lane i
    always_comb begin
        case (mem.size)
            3'd0:    lane_mask = 4'b0001;
            3'd1:    lane_mask = 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
        for (int i = 0; i < STRB_WIDTH; i++) begin
            lane_idx[i] = MEM_IDX_WIDTH'(mem.addr + addr_t'(i));
        end
    end

    assign end_addr = ({1'b0, mem.addr} + ((ADDR_WIDTH+1)'(1) << mem.size))
                      - (ADDR_WIDTH+1)'(1);
    assign mem.in_range = end_addr < (ADDR_WIDTH+1)'(MEM_DEPTH);

    always_comb begin
        mem.rdata = '0;                                // Unused lanes read zero
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (mem.in_range && lane_mask[i])
                mem.rdata[8*i +: 8] = mem_array[lane_idx[i]];
        end
    end

    // No writes while held in reset
    always_ff @(posedge clk) begin
        if (reset && mem.we) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (mem.wstrb[i] && lane_mask[i])
                    mem_array[lane_idx[i]] <= mem.wdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_port_if.sv */
/*
 * Single beat access port to the byte memory
 */
`timescale 1ns/100ps
`default_nettype none

interface mem_port_if import axi_mem_pkg::*; ();

    addr_t addr;        // Beat address, from the address generator
    size_t size;        // Beat size, from the address generator
    data_t wdata;       // Write lanes from the W channel
    strb_t wstrb;
    logic  we;          // One beat write at the next edge
    data_t rdata;       // Lane aligned read data
    logic  in_range;    // Whole beat fits inside the array

    modport host (
        output addr, size, wdata, wstrb, we,
        input  rdata, in_range
    );

    modport mem (
        input  addr, size, wdata, wstrb, we,
        output rdata, in_range
    );

endinterface

`default_nettype wire

/* hdl/slave_ctrl.sv */
/*
 * Channel controller for the memory slave
 * Four state FSM that owns every handshake, steers memory writes and
 * forms the R and B responses
 */
`timescale 1ns/100ps
`default_nettype none

module slave_ctrl import axi_mem_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic         arvalid,
    input  logic         awvalid,
    input  logic         wvalid,
    input  logic         rready,
    input  logic         bready,
    input  data_t        wdata,
    input  strb_t        wstrb,

    output logic         arready,
    output logic         awready,
    output logic         wready,
    output logic         rvalid,
    output id_t          rid,
    output data_t        rdata,
    output resp_t        rresp,
    output logic         rlast,
    output logic         bvalid,
    output id_t          bid,
    output resp_t        bresp,

    output logic         load,        // To the command register
    output logic         is_write,
    output logic         start,       // To the address generator
    output logic         advance,
    input  logic         last_beat,

    burst_cmd_if.cmd_dst cmd,
    mem_port_if.host     mem
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_RESP
    } state_t;

    state_t state;
    logic   ar_hs;
    logic   aw_hs;
    logic   r_hs;
    logic   w_hs;
    logic   wr_err;                                   // Sticky per write burst

    // Ready and valid outputs straight from the state
    assign arready = (state == ST_IDLE);
    assign awready = (state == ST_IDLE) && !arvalid;  // Reads win a tie
    assign rvalid  = (state == ST_READ);
    assign wready  = (state == ST_WRITE);
    assign bvalid  = (state == ST_RESP);

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign r_hs  = rvalid && rready;
    assign w_hs  = wvalid && wready;

    assign load     = ar_hs || aw_hs;
    assign is_write = aw_hs;
    assign start    = ar_hs || aw_hs;
    assign advance  = r_hs || w_hs;                   // One step per beat

    // Read data follows the current beat address
    assign rid   = cmd.id;
    assign rdata = mem.rdata;                         // Already zero when out of range
    assign rresp = mem.in_range ? RESP_OKAY : RESP_DECERR;
    assign rlast = last_beat;

    assign bid   = cmd.id;
    assign bresp = wr_err ? RESP_DECERR : RESP_OKAY;

    // Out of range beats are dropped, not written
    assign mem.wdata = wdata;
    assign mem.wstrb = wstrb;
    assign mem.we    = w_hs && mem.in_range;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state  <= ST_IDLE;
            wr_err <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    wr_err <= 1'b0;                   // Fresh flag for each burst
                    if (ar_hs)
                        state <= ST_READ;
                    else if (aw_hs)
                        state <= ST_WRITE;
                end
                ST_READ: begin
                    if (r_hs && last_beat)
                        state <= ST_IDLE;
                end
                ST_WRITE: begin
                    if (w_hs && !mem.in_range)
                        wr_err <= 1'b1;
                    if (w_hs && last_beat)
                        state <= ST_RESP;             // No WLAST, count decides
                end
                ST_RESP: begin
                    if (bready)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hdl/axi_mem_pkg.sv
hdl/burst_cmd_if.sv
hdl/mem_port_if.sv
hdl/burst_cmd_reg.sv
hdl/burst_addr_gen.sv
hdl/slave_ctrl.sv
hdl/byte_mem.sv
hdl/axi_mem_slave.sv
test/tb_axi_mem_slave.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f list.f \
    --top-module tb_axi_mem_slave \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* include/tb_model.svh */
/*
 * Testbench reference model for the memory slave
 * Mirror byte array, expected beat addresses and an xorshift source
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0]  model_mem [MEM_DEPTH];
logic [31:0] rng_state = 32'd89;                   // Shared generator state

// 32 bit xorshift, advances the shared state
function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Address of beat n within a burst
function automatic addr_t beat_addr(addr_t start, size_t size, len_t len,
                                    burst_t burst, int n);
    int nbytes;
    int total;
    int base;
    int offs;
    nbytes = 1 << size;
    total  = nbytes * (int'(len) + 1);
    case (burst)
        BURST_FIXED: return start;
        BURST_WRAP: begin
            base = (int'(start) / total) * total;  // Block holding the start address
            offs = (int'(start) - base + n * nbytes) % total;
            return addr_t'(base + offs);
        end
        default: return addr_t'(int'(start) + n * nbytes);
    endcase
endfunction

function automatic bit model_in_range(addr_t a, size_t size);
    return (int'(a) + (1 << size) - 1) < MEM_DEPTH;
endfunction

// Mirrors one W beat, nothing lands when out of range
function automatic void model_write(addr_t a, size_t size, data_t wdata, strb_t wstrb);
    if (model_in_range(a, size)) begin
        for (int i = 0; i < (1 << size); i++) begin
            if (wstrb[i])
                model_mem[int'(a) + i] = wdata[8*i +: 8];
        end
    end
endfunction

// Expected rdata, zero beyond the beat size or the array end
function automatic data_t model_read(addr_t a, size_t size);
    data_t d;
    d = '0;
    if (model_in_range(a, size)) begin
        for (int i = 0; i < (1 << size); i++) begin
            d[8*i +: 8] = model_mem[int'(a) + i];
        end
    end
    return d;
endfunction

function automatic resp_t model_resp(addr_t a, size_t size);
    return model_in_range(a, size) ? RESP_OKAY : RESP_DECERR;
endfunction

`endif

/* test/tb_axi_mem_slave.sv */
/*
 * Testbench for the AXI burst memory slave
 * Random and directed bursts against a reference byte model, with every
 * R beat checked by a separate compare process
 */
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem_slave import axi_mem_pkg::*; ();

    `include "tb_model.svh"

    localparam int TIMEOUT = 2000;          // Cycles allowed for any one wait

    logic clk;
    logic reset;
    logic arvalid, rready, awvalid, wvalid, bready;
    id_t arid, awid, rid, bid;
    addr_t araddr, awaddr;
    len_t arlen, awlen;
    size_t arsize, awsize;
    logic [1:0] arburst, awburst, rresp, bresp;
    data_t wdata, rdata;
    strb_t wstrb;
    logic arready, rvalid, rlast, awready, wready, bvalid;

    // Read burst under check, shared with the compare process
    addr_t rd_addr;
    size_t rd_size;
    len_t rd_len;
    burst_t rd_burst;
    id_t rd_id;
    int rd_beat = 0;
    bit rd_active = 1'b0;

    // Values seen while the master stalls a beat
    bit held = 1'b0;
    data_t h_data;
    id_t h_id;
    logic [1:0] h_resp;
    logic h_last;

    int err_value = 0;
    int err_other = 0;
    bit timed_out = 1'b0;
    bit run_done = 1'b0;

    axi_mem_slave dut0 (.*);

    always #50 clk = ~clk;                  // 100 ns period

    function automatic int pick_below(int n);
        return int'(xorshift32() % n);
    endfunction

    // Ready level for R and B, low about one cycle in four when stalling
    function automatic logic pick_ready(bit stall);
        return stall ? (pick_below(4) != 0) : 1'b1;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
        err_value++;
    endtask

    task automatic timeout_hit(input string what);
        $display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
        err_other++;
        timed_out = 1'b1;
    endtask

    task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                               input size_t size, input burst_t burst,
                               input bit rnd_strb, input bit stall);
        int n;
        int wait_cnt;
        bit exp_err;
        addr_t a;
        n = 0;
        wait_cnt = 0;
        exp_err = 1'b0;
        @(posedge clk);
        #1;
        awvalid = 1'b1;
        awid = id;
        awaddr = addr;
        awlen = len;
        awsize = size;
        awburst = burst;
        @(negedge clk);
        while (!awready && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!awready) begin
            timeout_hit("awready");
            return;
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b1;
        wdata = xorshift32();
        wstrb = rnd_strb ? strb_t'(xorshift32()) : '1;
        wait_cnt = 0;
        while (n <= int'(len) && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            if (wready) begin
                a = beat_addr(addr, size, len, burst, n);   // Beat lands at the next edge
                model_write(a, size, wdata, wstrb);
                if (!model_in_range(a, size))
                    exp_err = 1'b1;
                n++;
            end else begin
                wait_cnt++;
            end
            @(posedge clk);
            #1;
            wdata = xorshift32();
            wstrb = rnd_strb ? strb_t'(xorshift32()) : '1;
        end
        wvalid = 1'b0;
        if (n <= int'(len)) begin
            timeout_hit("wready");
            return;
        end
        wait_cnt = 0;
        bready = pick_ready(stall);
        @(negedge clk);
        while (!(bvalid && bready) && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            bready = pick_ready(stall);
            @(negedge clk);
            wait_cnt++;
        end
        if (!(bvalid && bready)) begin
            timeout_hit("write response");
            return;
        end
        if (bid !== id)
            report_value("bid", 32'(id), 32'(bid));
        if (bresp !== (exp_err ? RESP_DECERR : RESP_OKAY))
            report_value("bresp", exp_err ? 32'(RESP_DECERR) : 32'(RESP_OKAY), 32'(bresp));
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_burst(input id_t id, input addr_t addr, input len_t len,
                              input size_t size, input burst_t burst, input bit stall);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk);
        #1;
        rd_addr = addr;
        rd_size = size;
        rd_len = len;
        rd_burst = burst;
        rd_id = id;
        rd_beat = 0;
        rd_active = 1'b1;
        arvalid = 1'b1;
        arid = id;
        araddr = addr;
        arlen = len;
        arsize = size;
        arburst = burst;
        @(negedge clk);
        while (!arready && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!arready) begin
            timeout_hit("arready");
            return;
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        wait_cnt = 0;
        // Beats are counted by the compare process
        while (rd_beat <= int'(len) && wait_cnt < TIMEOUT) begin
            rready = pick_ready(stall);
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        rready = 1'b0;
        rd_active = 1'b0;
        if (rd_beat <= int'(len))
            timeout_hit("last read beat");
    endtask

    // Compare process, mid cycle where DUT outputs and inputs have settled
    always @(negedge clk) begin
        addr_t a;
        if (held && rvalid) begin
            if (rdata !== h_data)
                report_value("rdata held", h_data, rdata);
            if (rid !== h_id)
                report_value("rid held", 32'(h_id), 32'(rid));
            if (rresp !== h_resp)
                report_value("rresp held", 32'(h_resp), 32'(rresp));
            if (rlast !== h_last)
                report_value("rlast held", 32'(h_last), 32'(rlast));
        end
        held = rvalid && !rready;
        h_data = rdata;
        h_id = rid;
        h_resp = rresp;
        h_last = rlast;
        // rvalid must be low outside a read burst and after its final beat
        if (rvalid && (!rd_active || rd_beat > int'(rd_len))) begin
            $display("rvalid high at %0t with no read beat outstanding", $time);
            err_other++;
        end else if (rvalid && rready) begin
            a = beat_addr(rd_addr, rd_size, rd_len, rd_burst, rd_beat);
            if (rdata !== model_read(a, rd_size))
                report_value("rdata", model_read(a, rd_size), rdata);
            if (rresp !== model_resp(a, rd_size))
                report_value("rresp", 32'(model_resp(a, rd_size)), 32'(rresp));
            if (rid !== rd_id)
                report_value("rid", 32'(rd_id), 32'(rid));
            if (rlast !== (rd_beat == int'(rd_len)))
                report_value("rlast", 32'(rd_beat == int'(rd_len)), 32'(rlast));
            rd_beat++;
        end
    end

    initial begin
        addr_t addr;
        len_t len;
        size_t size;
        int total;
        clk = 1'b0;
        reset = 1'b0;
        arvalid = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        arburst = '0;
        rready = 1'b0;
        awvalid = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = '0;
        awburst = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b1;

        @(negedge clk);
        if (rvalid !== 1'b0)
            report_value("rvalid after reset", 0, 32'(rvalid));
        if (wready !== 1'b0)
            report_value("wready after reset", 0, 32'(wready));
        if (bvalid !== 1'b0)
            report_value("bvalid after reset", 0, 32'(bvalid));
        if (arready !== 1'b1)
            report_value("arready after reset", 1, 32'(arready));
        if (awready !== 1'b1)
            report_value("awready after reset", 1, 32'(awready));

        // Whole array gets random bytes, so every later read has known contents
        write_burst(4'h1, '0, 8'd255, 3'd2, BURST_INCR, 1'b0, 1'b0);

        // INCR write then read back at each size
        for (int s = 0; s < 3; s++) begin
            size = size_t'(s);
            len = len_t'(1 + pick_below(12));
            addr = addr_t'(pick_below(MEM_DEPTH - (int'(len) + 1) * (1 << s)));
            write_burst(id_t'(pick_below(16)), addr, len, size, BURST_INCR, 1'b1, 1'b0);
            read_burst(id_t'(pick_below(16)), addr, len, size, BURST_INCR, 1'b0);
        end

        // FIXED, last strobed value per lane stays at one word
        addr = addr_t'(pick_below(MEM_DEPTH / 4) * 4);
        write_burst(4'h3, addr, 8'd5, 3'd2, BURST_FIXED, 1'b1, 1'b0);
        read_burst(4'h4, addr, 8'd5, 3'd2, BURST_FIXED, 1'b0);

        // WRAP of 2, 4, 8 and 16 beats starting inside the block
        for (int w = 1; w <= 4; w++) begin
            len = len_t'((1 << w) - 1);
            size = size_t'(pick_below(3));
            total = (int'(len) + 1) << size;
            addr = addr_t'(pick_below(MEM_DEPTH / total) * total
                           + (1 + pick_below(int'(len))) * (1 << size));
            read_burst(id_t'(w), addr, len, size, BURST_WRAP, 1'b0);
        end

        // Bursts running past the end of the array
        read_burst(4'h6, addr_t'(MEM_DEPTH - 8), 8'd3, 3'd2, BURST_INCR, 1'b0);
        read_burst(4'h7, addr_t'(MEM_DEPTH - 2), 8'd1, 3'd1, BURST_INCR, 1'b0);
        write_burst(4'h8, addr_t'(MEM_DEPTH - 8), 8'd3, 3'd2, BURST_INCR, 1'b0, 1'b0);
        read_burst(4'h9, addr_t'(MEM_DEPTH - 8), 8'd3, 3'd2, BURST_INCR, 1'b0);
        read_burst(4'hA, '0, 8'd3, 3'd2, BURST_INCR, 1'b0);   // Where a wrapped index lands

        // Random traffic with rready and bready stalls
        for (int k = 0; k < 12; k++) begin
            size = size_t'(pick_below(3));
            len = len_t'(pick_below(32));
            addr = addr_t'(pick_below(MEM_DEPTH));
            if (pick_below(2) == 0)
                write_burst(id_t'(pick_below(16)), addr, len, size, BURST_INCR, 1'b1, 1'b1);
            else
                read_burst(id_t'(pick_below(16)), addr, len, size, BURST_INCR, 1'b1);
        end
        read_burst(4'hB, '0, 8'd255, 3'd2, BURST_INCR, 1'b1);
        run_done = 1'b1;
    end

    // Ends the run after the last burst or the first timeout
    initial begin
        wait (run_done || timed_out);
        $display("Closing report: %0d value errors, %0d other errors", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
